// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_image_processing
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+src
src/image_proc_pkg.sv
src/host_command_fsm.sv
src/image_stream.sv
src/pixel_unary_engine.sv
src/memory_port.sv
src/image_processing.sv
testbench/tb_memory_model.sv
testbench/tb_image_processing.sv

// ==== src/host_command_fsm.sv ====
/*
 * Host command decoder
 * Decodes the byte-stream commands, captures their parameters, keeps
 * the image size and buffer roles, answers GET_STATUS and starts the
 * image stream and the pixel engine.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module host_command_fsm (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [7:0]                    comm_cmd,
   input  logic [7:0]                    comm_data_in,
   input  logic                          comm_data_in_valid,
   input  logic                          comm_data_out_free,
   input  logic                          stream_done,
   input  logic                          engine_busy,
   output logic [7:0]                    comm_data_out,
   output logic                          comm_data_out_valid,
   output logic                          stream_start,
   output logic                          stream_write,
   output logic [`IMG_ADDR_W-1:0]        stream_base,
   output logic [`IMG_COUNT_W-1:0]       pixel_count,
   output logic                          op_start,
   output image_proc_pkg::unary_op_e     op_code,
   output logic [15:0]                   add_value,
   output logic                          clamp_en,
   output logic [`IMG_PIXEL_W-1:0]       thresh_value,
   output logic [`IMG_PIXEL_W-1:0]       thresh_repl,
   output logic                          thresh_upper,
   output logic [`IMG_ADDR_W-1:0]        storage_base
);

   typedef enum logic [2:0] {F_IDLE, F_PARAM, F_ADD, F_THRESH, F_STATUS, F_STREAM} state_e;

   state_e                 state;
   logic [1:0]             idx;
   logic [`IMG_DIM_W-1:0]  width_q;
   logic [`IMG_DIM_W-1:0]  height_q;
   logic [7:0]             status_byte;

   assign pixel_count = width_q * height_q;

   always_comb begin
      case (idx)
         2'd0: begin
            status_byte = `STATUS_BYTE0;
            status_byte[0] = engine_busy;
         end
         2'd1: status_byte = `STATUS_BYTE1;
         2'd2: status_byte = `STATUS_BYTE2;
         default: status_byte = `STATUS_BYTE3;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= F_IDLE;
         idx <= '0;
         stream_start <= 1'b0;
         stream_write <= 1'b0;
         op_start <= 1'b0;
         op_code <= image_proc_pkg::OP_ADD;
         comm_data_out_valid <= 1'b0;
         width_q <= '0;
         height_q <= '0;
         stream_base <= '0;
         storage_base <= `IMG_BUFFER2_BASE;
      end else begin
         stream_start <= 1'b0;
         op_start <= 1'b0;
         comm_data_out_valid <= 1'b0;
         case (state)
            F_IDLE: if (comm_data_in_valid) begin
               idx <= '0;
               case (comm_cmd)
                  image_proc_pkg::CMD_PARAM: begin
                     state <= F_PARAM;
                     stream_base <= '0;
                     storage_base <= `IMG_BUFFER2_BASE;
                  end
                  image_proc_pkg::CMD_SEND_IMG: begin
                     state <= F_STREAM;
                     stream_start <= 1'b1;
                     stream_write <= 1'b1;
                  end
                  image_proc_pkg::CMD_READ_IMG: begin
                     state <= F_STREAM;
                     stream_start <= 1'b1;
                     stream_write <= 1'b0;
                  end
                  image_proc_pkg::CMD_GET_STATUS: state <= F_STATUS;
                  image_proc_pkg::CMD_APPLY_ADD: begin
                     state <= F_ADD;
                     op_code <= image_proc_pkg::OP_ADD;
                  end
                  image_proc_pkg::CMD_APPLY_THRESHOLD: begin
                     state <= F_THRESH;
                     op_code <= image_proc_pkg::OP_THRESHOLD;
                  end
                  image_proc_pkg::CMD_SWITCH_BUFFERS: begin
                     stream_base <= storage_base;
                     storage_base <= stream_base;
                  end
                  image_proc_pkg::CMD_APPLY_INVERT: begin
                     op_code <= image_proc_pkg::OP_INVERT;
                     op_start <= 1'b1;
                  end
                  default: ;
               endcase
            end
            // width lo, width hi, height lo, height hi
            F_PARAM: if (comm_data_in_valid) begin
               idx <= idx + 1'b1;
               case (idx)
                  2'd0: width_q[7:0] <= comm_data_in;
                  2'd1: width_q[15:8] <= comm_data_in;
                  2'd2: height_q[7:0] <= comm_data_in;
                  default: begin
                     height_q[15:8] <= comm_data_in;
                     state <= F_IDLE;
                  end
               endcase
            end
            // three bytes each, the flags byte is last
            F_ADD, F_THRESH: if (comm_data_in_valid) begin
               idx <= idx + 1'b1;
               if (idx == 2'd2) begin
                  op_start <= 1'b1;
                  state <= F_IDLE;
               end
            end
            F_STATUS: if (comm_data_out_free) begin
               comm_data_out_valid <= 1'b1;
               idx <= idx + 1'b1;
               if (idx == 2'd3) state <= F_IDLE;
            end
            F_STREAM: if (stream_done) state <= F_IDLE;
            default: state <= F_IDLE;
         endcase
      end
   end

   // operation parameters and the reply byte
   always_ff @(posedge clk) begin
      comm_data_out <= '0;
      if (state == F_STATUS && comm_data_out_free) comm_data_out <= status_byte;
      if (comm_data_in_valid && state == F_ADD) begin
         case (idx)
            2'd0: add_value[7:0] <= comm_data_in;
            2'd1: add_value[15:8] <= comm_data_in;
            default: clamp_en <= comm_data_in[0];
         endcase
      end
      if (comm_data_in_valid && state == F_THRESH) begin
         case (idx)
            2'd0: thresh_value <= comm_data_in;
            2'd1: thresh_repl <= comm_data_in;
            default: thresh_upper <= comm_data_in[0];
         endcase
      end
   end

   // while the engine runs the host may only poll the status
   a_busy_status_only: assert property (@(posedge clk) disable iff (reset)
      (state == F_IDLE && comm_data_in_valid && engine_busy)
         |-> comm_cmd == image_proc_pkg::CMD_GET_STATUS)
      else $error("host_command_fsm: command %0d accepted while busy", comm_cmd);

endmodule

`default_nettype wire

// ==== src/image_proc_params.svh ====
/*
 * Image coprocessor constants
 * Widths, external memory layout and the fixed GET_STATUS reply bytes.
 */
`ifndef IMAGE_PROC_PARAMS_SVH
`define IMAGE_PROC_PARAMS_SVH

// memory byte address and data word
`define IMG_ADDR_W 17
`define IMG_WORD_W 16

// pixel and image geometry
`define IMG_PIXEL_W 8
`define IMG_DIM_W 16
`define IMG_COUNT_W 32

// second 64 KB buffer
`define IMG_BUFFER2_BASE 17'd65536

// status reply, bit 0 of byte 0 is replaced by busy
`define STATUS_BYTE0 8'h11
`define STATUS_BYTE1 8'h22
`define STATUS_BYTE2 8'h33
`define STATUS_BYTE3 8'h44

`endif

// ==== src/image_proc_pkg.sv ====
/*
 * Image coprocessor types
 * Host command codes, unary operation select and the two views
 * of one 16-bit memory word.
 */
`default_nettype none

`include "image_proc_params.svh"

package image_proc_pkg;

   // host command codes, the missing ones are ignored
   typedef enum logic [7:0] {
      CMD_PARAM           = 8'd0,
      CMD_SEND_IMG        = 8'd1,
      CMD_READ_IMG        = 8'd2,
      CMD_GET_STATUS      = 8'd3,
      CMD_APPLY_ADD       = 8'd4,
      CMD_APPLY_THRESHOLD = 8'd5,
      CMD_SWITCH_BUFFERS  = 8'd6,
      CMD_APPLY_INVERT    = 8'd8
   } cmd_e;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_THRESHOLD,
      OP_INVERT
   } unary_op_e;

   // lo is the pixel at the even byte address
   typedef struct packed {
      logic [`IMG_PIXEL_W-1:0] hi;
      logic [`IMG_PIXEL_W-1:0] lo;
   } pixel_pair_t;

   typedef union packed {
      logic [`IMG_WORD_W-1:0] raw;
      pixel_pair_t            px;
   } mem_word_t;

endpackage

`default_nettype wire

// ==== src/image_processing.sv ====
/*
 * Image coprocessor top level
 * Host byte interface and 16-bit memory port around the command
 * decoder, the image stream, the pixel engine and the memory port.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module image_processing (
   input  logic                    clk,
   input  logic                    reset,
   output logic [`IMG_ADDR_W-1:0]  addr,
   output logic                    wr_en,
   output logic                    rd_en,
   output logic [`IMG_WORD_W-1:0]  data_write,
   input  logic [`IMG_WORD_W-1:0]  data_read,
   input  logic                    data_read_valid,
   input  logic [7:0]              comm_cmd,
   input  logic [7:0]              comm_data_in,
   input  logic                    comm_data_in_valid,
   output logic [7:0]              comm_data_out,
   output logic                    comm_data_out_valid,
   input  logic                    comm_data_out_free
);

   logic                        stream_start;
   logic                        stream_write;
   logic [`IMG_ADDR_W-1:0]      stream_base;
   logic [`IMG_COUNT_W-1:0]     pixel_count;
   logic                        stream_done;
   logic                        stream_active;
   logic                        stream_rd;
   logic                        stream_wr;
   logic [`IMG_ADDR_W-1:0]      stream_addr;
   logic [`IMG_WORD_W-1:0]      stream_wdata;
   logic [7:0]                  stream_data_out;
   logic                        stream_data_out_valid;
   logic [7:0]                  status_data;
   logic                        status_valid;
   logic                        op_start;
   image_proc_pkg::unary_op_e   op_code;
   logic [15:0]                 add_value;
   logic                        clamp_en;
   logic [`IMG_PIXEL_W-1:0]     thresh_value;
   logic [`IMG_PIXEL_W-1:0]     thresh_repl;
   logic                        thresh_upper;
   logic [`IMG_ADDR_W-1:0]      storage_base;
   logic                        engine_busy;
   logic                        eng_rd;
   logic                        eng_wr;
   logic [`IMG_ADDR_W-1:0]      eng_addr;
   logic [`IMG_WORD_W-1:0]      eng_wdata;

   // both sources hold zero when idle, never both at once
   assign comm_data_out = status_data | stream_data_out;
   assign comm_data_out_valid = status_valid | stream_data_out_valid;

   host_command_fsm u_cmd (
      .clk, .reset, .comm_cmd, .comm_data_in, .comm_data_in_valid, .comm_data_out_free,
      .stream_done, .engine_busy,
      .comm_data_out(status_data), .comm_data_out_valid(status_valid),
      .stream_start, .stream_write, .stream_base, .pixel_count,
      .op_start, .op_code, .add_value, .clamp_en, .thresh_value, .thresh_repl,
      .thresh_upper, .storage_base
   );

   image_stream u_stream (
      .clk, .reset, .stream_start, .stream_write, .stream_base, .pixel_count,
      .comm_data_in, .comm_data_in_valid, .comm_data_out_free, .data_read, .data_read_valid,
      .stream_active, .stream_done, .stream_rd, .stream_wr, .stream_addr, .stream_wdata,
      .stream_data_out, .stream_data_out_valid
   );

   pixel_unary_engine u_engine (
      .clk, .reset, .op_start, .op_code, .add_value, .clamp_en, .thresh_value,
      .thresh_repl, .thresh_upper, .storage_base, .pixel_count, .data_read,
      .data_read_valid, .engine_busy, .eng_rd, .eng_wr, .eng_addr, .eng_wdata
   );

   memory_port u_mem (
      .clk, .reset, .stream_active, .stream_rd, .stream_wr, .stream_addr, .stream_wdata,
      .eng_rd, .eng_wr, .eng_addr, .eng_wdata, .addr, .wr_en, .rd_en, .data_write
   );

endmodule

`default_nettype wire

// ==== src/image_stream.sv ====
/*
 * Image byte stream
 * SEND packs host bytes into memory words and writes them to the input
 * buffer. READ fetches words and returns lo then hi under back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module image_stream (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    stream_start,
   input  logic                    stream_write,
   input  logic [`IMG_ADDR_W-1:0]  stream_base,
   input  logic [`IMG_COUNT_W-1:0] pixel_count,
   input  logic [7:0]              comm_data_in,
   input  logic                    comm_data_in_valid,
   input  logic                    comm_data_out_free,
   input  logic [`IMG_WORD_W-1:0]  data_read,
   input  logic                    data_read_valid,
   output logic                    stream_active,
   output logic                    stream_done,
   output logic                    stream_rd,
   output logic                    stream_wr,
   output logic [`IMG_ADDR_W-1:0]  stream_addr,
   output logic [`IMG_WORD_W-1:0]  stream_wdata,
   output logic [7:0]              stream_data_out,
   output logic                    stream_data_out_valid
);

   typedef enum logic [2:0] {S_IDLE, S_SEND, S_RD_REQ, S_RD_WAIT, S_RD_LO, S_RD_HI} state_e;

   state_e                      state;
   logic [`IMG_ADDR_W-1:0]      addr_q;
   logic [`IMG_COUNT_W-1:0]     count_q;
   logic [`IMG_PIXEL_W-1:0]     lo_q;
   image_proc_pkg::mem_word_t   rd_word_q;
   image_proc_pkg::mem_word_t   wr_word;
   logic                        sending;
   logic                        take;
   logic                        emit;
   logic                        last_word;
   logic [`IMG_ADDR_W-1:0]      byte_addr;
   logic [`IMG_COUNT_W-1:0]     bytes_left;

   // first pixel byte may already come with the start pulse
   assign sending = stream_start ? stream_write : (state == S_SEND);
   assign byte_addr = stream_start ? stream_base : addr_q;
   assign bytes_left = stream_start ? pixel_count : count_q;
   assign take = sending && comm_data_in_valid;
   assign emit = (state == S_RD_LO || state == S_RD_HI) && comm_data_out_free;
   assign last_word = (count_q == 2);

   always_comb begin
      wr_word.px.lo = lo_q;
      wr_word.px.hi = comm_data_in;
   end

   // odd byte completes the word
   assign stream_wr = take && byte_addr[0];
   assign stream_wdata = wr_word.raw;
   assign stream_rd = (state == S_RD_REQ);
   assign stream_addr = {byte_addr[`IMG_ADDR_W-1:1], 1'b0};
   assign stream_active = stream_start || (state != S_IDLE);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
         stream_done <= 1'b0;
         stream_data_out_valid <= 1'b0;
      end else begin
         stream_done <= 1'b0;
         stream_data_out_valid <= emit;
         if (take) begin
            state <= (bytes_left == 1) ? S_IDLE : S_SEND;
            stream_done <= (bytes_left == 1);
         end else if (stream_start) begin
            state <= stream_write ? S_SEND : S_RD_REQ;
         end else begin
            case (state)
               S_RD_REQ: state <= S_RD_WAIT;
               S_RD_WAIT: if (data_read_valid) state <= S_RD_LO;
               S_RD_LO: if (comm_data_out_free) state <= S_RD_HI;
               S_RD_HI: if (comm_data_out_free) begin
                  state <= last_word ? S_IDLE : S_RD_REQ;
                  stream_done <= last_word;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      stream_data_out <= '0;
      if (take) begin
         addr_q <= byte_addr + 1'b1;
         count_q <= bytes_left - 1'b1;
         if (!byte_addr[0]) lo_q <= comm_data_in;
      end else if (stream_start) begin
         addr_q <= stream_base;
         count_q <= pixel_count;
      end else if (state == S_RD_HI && comm_data_out_free) begin
         addr_q <= addr_q + 2'd2;
         count_q <= count_q - 2'd2;
      end
      if (state == S_RD_WAIT && data_read_valid) rd_word_q.raw <= data_read;
      if (emit) stream_data_out <= (state == S_RD_LO) ? rd_word_q.px.lo : rd_word_q.px.hi;
   end

endmodule

`default_nettype wire

// ==== src/memory_port.sv ====
/*
 * Memory port
 * Registers the request of the active block onto the memory pins,
 * the image stream while it runs, otherwise the pixel engine.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module memory_port (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    stream_active,
   input  logic                    stream_rd,
   input  logic                    stream_wr,
   input  logic [`IMG_ADDR_W-1:0]  stream_addr,
   input  logic [`IMG_WORD_W-1:0]  stream_wdata,
   input  logic                    eng_rd,
   input  logic                    eng_wr,
   input  logic [`IMG_ADDR_W-1:0]  eng_addr,
   input  logic [`IMG_WORD_W-1:0]  eng_wdata,
   output logic [`IMG_ADDR_W-1:0]  addr,
   output logic                    wr_en,
   output logic                    rd_en,
   output logic [`IMG_WORD_W-1:0]  data_write
);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_en <= 1'b0;
         rd_en <= 1'b0;
      end else begin
         wr_en <= stream_active ? stream_wr : eng_wr;
         rd_en <= stream_active ? stream_rd : eng_rd;
      end
   end

   always_ff @(posedge clk) begin
      addr <= stream_active ? stream_addr : eng_addr;
      data_write <= stream_active ? stream_wdata : eng_wdata;
   end

   // the deselected block must stay off the bus
   a_engine_quiet: assert property (@(posedge clk) disable iff (reset)
      stream_active |-> !(eng_rd || eng_wr))
      else $error("memory_port: engine request during image stream");

   a_stream_quiet: assert property (@(posedge clk) disable iff (reset)
      !stream_active |-> !(stream_rd || stream_wr))
      else $error("memory_port: stream request while stream inactive");

endmodule

`default_nettype wire

// ==== src/pixel_unary_engine.sv ====
/*
 * Unary pixel engine
 * Rewrites the storage buffer in place, one word at a time:
 * read, wait for data, write back with add, threshold or invert applied.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module pixel_unary_engine (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       op_start,
   input  image_proc_pkg::unary_op_e  op_code,
   input  logic [15:0]                add_value,
   input  logic                       clamp_en,
   input  logic [`IMG_PIXEL_W-1:0]    thresh_value,
   input  logic [`IMG_PIXEL_W-1:0]    thresh_repl,
   input  logic                       thresh_upper,
   input  logic [`IMG_ADDR_W-1:0]     storage_base,
   input  logic [`IMG_COUNT_W-1:0]    pixel_count,
   input  logic [`IMG_WORD_W-1:0]     data_read,
   input  logic                       data_read_valid,
   output logic                       engine_busy,
   output logic                       eng_rd,
   output logic                       eng_wr,
   output logic [`IMG_ADDR_W-1:0]     eng_addr,
   output logic [`IMG_WORD_W-1:0]     eng_wdata
);

   typedef enum logic [1:0] {E_IDLE, E_READ, E_WAIT, E_WRITE} state_e;

   state_e                      state;
   logic [`IMG_ADDR_W-1:0]      addr_q;
   logic [`IMG_COUNT_W-1:0]     count_q;
   image_proc_pkg::mem_word_t   rd_word;
   image_proc_pkg::mem_word_t   new_word;
   image_proc_pkg::mem_word_t   result_q;

   // signed add, saturated to 0..255 only when clamping
   function automatic logic [7:0] add_pixel(input logic [7:0] p);
      logic signed [16:0] sum;
      sum = $signed({9'd0, p}) + $signed({add_value[15], add_value});
      if (!clamp_en) return sum[7:0];
      if (sum < 0) return 8'd0;
      if (sum > 17'sd255) return 8'hff;
      return sum[7:0];
   endfunction

   function automatic logic [7:0] thresh_pixel(input logic [7:0] p);
      logic hit;
      hit = thresh_upper ? (p >= thresh_value) : (p <= thresh_value);
      return hit ? thresh_repl : p;
   endfunction

   always_comb begin
      rd_word.raw = data_read;
      new_word = rd_word;
      case (op_code)
         image_proc_pkg::OP_ADD: begin
            new_word.px.lo = add_pixel(rd_word.px.lo);
            new_word.px.hi = add_pixel(rd_word.px.hi);
         end
         image_proc_pkg::OP_THRESHOLD: begin
            new_word.px.lo = thresh_pixel(rd_word.px.lo);
            new_word.px.hi = thresh_pixel(rd_word.px.hi);
         end
         default: new_word.raw = ~rd_word.raw;
      endcase
   end

   assign engine_busy = op_start || (state != E_IDLE);
   assign eng_rd = (state == E_READ);
   assign eng_wr = (state == E_WRITE);
   assign eng_addr = addr_q;
   assign eng_wdata = result_q.raw;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= E_IDLE;
      end else begin
         case (state)
            E_IDLE: if (op_start) state <= E_READ;
            E_READ: state <= E_WAIT;
            E_WAIT: if (data_read_valid) state <= E_WRITE;
            default: state <= (count_q <= 2) ? E_IDLE : E_READ;
         endcase
      end
   end

   // two pixels per word
   always_ff @(posedge clk) begin
      if (op_start) begin
         addr_q <= storage_base;
         count_q <= pixel_count;
      end else if (state == E_WRITE) begin
         addr_q <= addr_q + 2'd2;
         count_q <= count_q - 2'd2;
      end
      if (state == E_WAIT && data_read_valid) result_q <= new_word;
   end

   a_no_restart: assert property (@(posedge clk) disable iff (reset)
      op_start |-> state == E_IDLE)
      else $error("pixel_unary_engine: op_start while an operation runs");

endmodule

`default_nettype wire

// ==== testbench/tb_image_processing.sv ====
/*
 * Image coprocessor testbench
 * Drives the host byte interface through status, image transfer,
 * add, threshold, invert and an unsupported command code, and checks
 * the replies and the memory contents against the command rules.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module tb_image_processing;

   localparam int IMG_W = 16;
   localparam int IMG_H = 16;
   localparam int NPIX = IMG_W * IMG_H;
   // many times six 16x16 transfers with stalls plus the operations
   localparam int CYCLE_LIMIT = 200000;
   localparam logic [31:0] RAND_SEED = 32'hf664_ba38;
   localparam logic [7:0] STATUS0_IDLE = `STATUS_BYTE0 & 8'hfe;

   logic                    clk = 1'b0;
   logic                    reset;
   logic [`IMG_ADDR_W-1:0]  addr;
   logic                    wr_en;
   logic                    rd_en;
   logic [`IMG_WORD_W-1:0]  data_write;
   logic [`IMG_WORD_W-1:0]  data_read;
   logic                    data_read_valid;
   logic [7:0]              comm_cmd;
   logic [7:0]              comm_data_in;
   logic                    comm_data_in_valid;
   logic [7:0]              comm_data_out;
   logic                    comm_data_out_valid;
   logic                    comm_data_out_free;

   logic [7:0]  img [0:NPIX-1];
   logic [7:0]  expect_px [0:NPIX-1];
   int          byte_errors = 0;
   int          word_errors = 0;
   int          other_errors = 0;
   int          cycle_count = 0;

   image_processing uut (
      .clk, .reset, .addr, .wr_en, .rd_en, .data_write, .data_read, .data_read_valid,
      .comm_cmd, .comm_data_in, .comm_data_in_valid, .comm_data_out,
      .comm_data_out_valid, .comm_data_out_free
   );

   tb_memory_model mem_model (
      .clk, .reset, .addr, .wr_en, .rd_en, .data_write, .data_read, .data_read_valid
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      if (actual !== expected) begin
         byte_errors++;
         $display("ERROR %0d ns %s: expected %02h, got %02h", $time, name, expected, actual);
      end
   endtask

   task automatic check_word(input string name, input image_proc_pkg::mem_word_t expected,
                             input image_proc_pkg::mem_word_t actual);
      if (actual.raw !== expected.raw) begin
         word_errors++;
         $display("ERROR %0d ns %s: expected %04h, got %04h", $time, name,
                  expected.raw, actual.raw);
      end
   endtask

   // every host task starts and ends 1 ns after a rising edge
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      comm_data_in = b;
      comm_data_in_valid = 1'b1;
      @(posedge clk);
      #1;
      comm_data_in_valid = 1'b0;
   endtask

   task automatic send_cmd(input logic [7:0] c);
      comm_cmd = c;
      send_byte(8'h00);
   endtask

   // valid is a pulse so look at it in the middle of every cycle
   task automatic read_byte(output logic [7:0] b, input bit stall);
      bit got;
      got = 1'b0;
      while (!got) begin
         comm_data_out_free = stall ? (($urandom % 4) != 0) : 1'b1;
         @(negedge clk);
         if (comm_data_out_valid) begin
            b = comm_data_out;
            got = 1'b1;
         end
         @(posedge clk);
         #1;
      end
   endtask

   task automatic get_status(output logic busy);
      logic [7:0] b;
      send_cmd(image_proc_pkg::CMD_GET_STATUS);
      read_byte(b, 1'b0);
      busy = b[0];
      check_byte("status byte 0", STATUS0_IDLE | {7'd0, b[0]}, b);
      read_byte(b, 1'b0);
      check_byte("status byte 1", `STATUS_BYTE1, b);
      read_byte(b, 1'b0);
      check_byte("status byte 2", `STATUS_BYTE2, b);
      read_byte(b, 1'b0);
      check_byte("status byte 3", `STATUS_BYTE3, b);
   endtask

   task automatic wait_idle(output bit busy_seen);
      logic busy;
      busy_seen = 1'b0;
      busy = 1'b1;
      while (busy) begin
         get_status(busy);
         if (busy) busy_seen = 1'b1;
      end
   endtask

   task automatic set_size(input logic [15:0] w, input logic [15:0] h);
      send_cmd(image_proc_pkg::CMD_PARAM);
      send_byte(w[7:0]);
      send_byte(w[15:8]);
      send_byte(h[7:0]);
      send_byte(h[15:8]);
   endtask

   task automatic send_image();
      send_cmd(image_proc_pkg::CMD_SEND_IMG);
      for (int i = 0; i < NPIX; i++) send_byte(img[i]);
      // stream_done reaches the decoder one cycle later
      idle_cycles(2);
   endtask

   task automatic read_image_check(input string what);
      logic [7:0] b;
      send_cmd(image_proc_pkg::CMD_READ_IMG);
      for (int i = 0; i < NPIX; i++) begin
         read_byte(b, 1'b1);
         check_byte($sformatf("comm_data_out %s pixel %0d", what, i), expect_px[i], b);
      end
      comm_data_out_free = 1'b1;
      idle_cycles(2);
   endtask

   task automatic check_memory(input int base);
      image_proc_pkg::mem_word_t exp_w;
      image_proc_pkg::mem_word_t act_w;
      int a;
      for (int w = 0; w < NPIX / 2; w++) begin
         a = base + 2 * w;
         exp_w.px.lo = expect_px[2 * w];
         exp_w.px.hi = expect_px[2 * w + 1];
         act_w.raw = mem_model.mem[a / 2];
         check_word($sformatf("mem[%05h]", a), exp_w, act_w);
      end
   endtask

   // fresh random image into the buffer that the operations rewrite
   task automatic load_storage();
      set_size(IMG_W[15:0], IMG_H[15:0]);
      for (int i = 0; i < NPIX; i++) img[i] = 8'($urandom);
      send_image();
      send_cmd(image_proc_pkg::CMD_SWITCH_BUFFERS);
   endtask

   function automatic logic [7:0] add_expected(input logic [7:0] p, input int value,
                                               input bit clamp);
      int sum;
      sum = int'(p) + value;
      if (clamp && sum < 0) return 8'd0;
      if (clamp && sum > 255) return 8'd255;
      return sum[7:0];
   endfunction

   function automatic logic [7:0] threshold_expected(input logic [7:0] p, input logic [7:0] t,
                                                     input logic [7:0] r, input bit upper);
      if (upper && p >= t) return r;
      if (!upper && p <= t) return r;
      return p;
   endfunction

   task automatic test_reset_status();
      logic [7:0] b;
      send_cmd(image_proc_pkg::CMD_GET_STATUS);
      // bit 0 of the first byte is busy and clear after reset
      read_byte(b, 1'b0);
      check_byte("status byte 0", STATUS0_IDLE, b);
      read_byte(b, 1'b0);
      check_byte("status byte 1", `STATUS_BYTE1, b);
      read_byte(b, 1'b0);
      check_byte("status byte 2", `STATUS_BYTE2, b);
      read_byte(b, 1'b0);
      check_byte("status byte 3", `STATUS_BYTE3, b);
   endtask

   task automatic test_send_read();
      set_size(IMG_W[15:0], IMG_H[15:0]);
      for (int i = 0; i < NPIX; i++) begin
         img[i] = 8'($urandom);
         expect_px[i] = img[i];
      end
      send_image();
      read_image_check("readback");
      check_memory(0);
   endtask

   task automatic test_add(input int value, input bit clamp);
      bit seen;
      load_storage();
      send_cmd(image_proc_pkg::CMD_APPLY_ADD);
      send_byte(value[7:0]);
      send_byte(value[15:8]);
      send_byte({7'd0, clamp});
      wait_idle(seen);
      if (!seen) begin
         other_errors++;
         $display("status busy bit never read as 1 during APPLY_ADD %0d", value);
      end
      for (int i = 0; i < NPIX; i++) expect_px[i] = add_expected(img[i], value, clamp);
      // result becomes the input buffer again
      send_cmd(image_proc_pkg::CMD_SWITCH_BUFFERS);
      read_image_check($sformatf("add %0d", value));
      check_memory(0);
   endtask

   task automatic test_threshold(input logic [7:0] t, input logic [7:0] r, input bit upper);
      bit seen;
      load_storage();
      send_cmd(image_proc_pkg::CMD_APPLY_THRESHOLD);
      send_byte(t);
      send_byte(r);
      send_byte({7'd0, upper});
      wait_idle(seen);
      for (int i = 0; i < NPIX; i++) expect_px[i] = threshold_expected(img[i], t, r, upper);
      check_memory(0);
   endtask

   task automatic test_invert();
      bit seen;
      load_storage();
      send_cmd(image_proc_pkg::CMD_APPLY_INVERT);
      wait_idle(seen);
      for (int i = 0; i < NPIX; i++) expect_px[i] = ~img[i];
      check_memory(0);
   endtask

   task automatic test_dropped_cmd();
      logic busy;
      // storage buffer still holds the inverted image
      for (int i = 0; i < NPIX; i++) expect_px[i] = ~img[i];
      send_cmd(8'd9);
      idle_cycles(4);
      get_status(busy);
      if (busy !== 1'b0) begin
         other_errors++;
         $display("busy bit set after an unsupported command code");
      end
      check_memory(0);
   endtask

   initial begin
      int total;
      void'($urandom(RAND_SEED));
      reset = 1'b1;
      comm_cmd = 8'h00;
      comm_data_in = 8'h00;
      comm_data_in_valid = 1'b0;
      comm_data_out_free = 1'b1;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      idle_cycles(2);

      test_reset_status();
      test_send_read();
      test_add(100, 1'b1);
      test_add(-50, 1'b0);
      test_threshold(8'd128, 8'h5a, 1'b1);
      test_threshold(8'd100, 8'hc3, 1'b0);
      test_invert();
      test_dropped_cmd();

      total = byte_errors + word_errors + other_errors;
      $display("errors: %0d byte, %0d memory word, %0d other", byte_errors, word_errors,
               other_errors);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_memory_model.sv ====
/*
 * External image memory model
 * 128 KB as 64K words of 16 bits. Reads return one cycle after rd_en
 * together with a valid strobe; writes store the whole word.
 */
`timescale 1ns/1ps
`default_nettype none

`include "image_proc_params.svh"

module tb_memory_model (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`IMG_ADDR_W-1:0]  addr,
   input  logic                    wr_en,
   input  logic                    rd_en,
   input  logic [`IMG_WORD_W-1:0]  data_write,
   output logic [`IMG_WORD_W-1:0]  data_read,
   output logic                    data_read_valid
);

   logic [`IMG_WORD_W-1:0] mem [0:65535];

   // fill depends on every bit of the word address
   initial begin
      for (int i = 0; i < 65536; i++) begin
         mem[i] = {i[7:0], i[15:8]} ^ 16'ha5c3;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         data_read_valid <= 1'b0;
      end else begin
         data_read_valid <= rd_en;
      end
      if (rd_en) data_read <= mem[addr[`IMG_ADDR_W-1:1]];
      if (wr_en) mem[addr[`IMG_ADDR_W-1:1]] <= data_write;
   end

endmodule

`default_nettype wire
